// File: common/sd_pkg.sv
package sd_pkg;

    // ========================================================================
    // field widths
    // ========================================================================

    // command index, also the index echoed in a short response
    typedef logic [5:0]  cmd_index_t;
    // command argument or response payload
    typedef logic [31:0] cmd_arg_t;
    typedef logic [6:0]  crc7_t;
    // counts bits inside one 48-bit frame
    typedef logic [5:0]  bit_cnt_t;

    // ========================================================================
    // frame constants
    // ========================================================================

    // start + dir + index + arg + crc + end
    parameter int FRAME_BITS = 48;
    parameter int CRC_BITS   = 7;

    // ========================================================================
    // fsm states
    // ========================================================================

    // transmitter
    typedef enum logic [1:0] {TX_IDLE, TX_SHIFT, TX_CRC, TX_END} tx_state_e;

    // receiver
    typedef enum logic [1:0] {RX_IDLE, RX_HUNT, RX_SHIFT, RX_DONE} rx_state_e;

    // sequencer
    typedef enum logic [1:0] {SEQ_IDLE, SEQ_CMD, SEQ_RESP, SEQ_DONE} seq_state_e;

endpackage

// File: common/sd_cmd_ifs.sv
`timescale 1ns/10ps

// sequencer to transmitter
interface sd_tx_if;
    // request side, from the sequencer
    logic               tx_start;
    sd_pkg::cmd_index_t tx_index;
    sd_pkg::cmd_arg_t   tx_arg;
    // status side, from the transmitter
    logic               tx_busy;
    logic               tx_done;

    modport sequencer (
        output tx_start, tx_index, tx_arg,
        input  tx_busy, tx_done
    );

    modport transmitter (
        input  tx_start, tx_index, tx_arg,
        output tx_busy, tx_done
    );
endinterface

// sequencer to receiver
interface sd_rx_if;
    logic               rx_arm;
    // result fields, valid from rx_done until the next arm
    logic               rx_done;
    sd_pkg::cmd_index_t rx_index;
    sd_pkg::cmd_arg_t   rx_arg;
    logic               rx_crc_ok;
    logic               rx_frame_ok;
    logic               rx_timeout;

    modport sequencer (
        output rx_arm,
        input  rx_done, rx_index, rx_arg, rx_crc_ok, rx_frame_ok, rx_timeout
    );

    modport receiver (
        input  rx_arm,
        output rx_done, rx_index, rx_arg, rx_crc_ok, rx_frame_ok, rx_timeout
    );
endinterface

// File: hw/sd_clk_gen.sv
`timescale 1ns/10ps

module sd_clk_gen #(
    parameter int CLK_DIV = 2
) (
    input  logic int_clk,
    input  logic en,
    output logic sd_clk_lvl,
    output logic sd_rise,
    output logic sd_fall
);

    // at least one bit even for CLK_DIV of 1
    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    // last int_clk of a half period
    assign wrap = (cnt == CNT_W'(CLK_DIV - 1));

    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            cnt        <= '0;
            sd_clk_lvl <= 1'b0;
            sd_rise    <= 1'b0;
            sd_fall    <= 1'b0;
        end else begin
            // strobes land in the same cycle as the new level
            sd_rise <= wrap && !sd_clk_lvl;
            sd_fall <= wrap && sd_clk_lvl;
            if (wrap) begin
                cnt        <= '0;
                sd_clk_lvl <= ~sd_clk_lvl;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: hw/crc7.sv
`timescale 1ns/10ps

module crc7 (
    input  logic          int_clk,
    input  logic          en,
    input  logic          clear,
    input  logic          bit_en,
    input  logic          din,
    output sd_pkg::crc7_t crc,
    output sd_pkg::crc7_t crc_next
);

    logic fb;

    // x^7 + x^3 + 1, msb first
    assign fb       = din ^ crc[6];
    assign crc_next = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};

    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (bit_en) begin
            crc <= crc_next;
        end
    end

endmodule

// File: cmd_path/cmd_tx.sv
`timescale 1ns/10ps

module cmd_tx (
    input  logic int_clk,
    input  logic en,
    input  logic sd_fall,
    sd_tx_if.transmitter tx,
    output logic sd_cmd_out,
    output logic sd_cmd_oe
);

    // bit 39 is the last bit covered by the crc
    localparam sd_pkg::bit_cnt_t LAST_DATA =
        sd_pkg::bit_cnt_t'(sd_pkg::FRAME_BITS - sd_pkg::CRC_BITS - 2);
    localparam sd_pkg::bit_cnt_t LAST_BIT = sd_pkg::bit_cnt_t'(sd_pkg::FRAME_BITS - 1);

    sd_pkg::tx_state_e             state;
    sd_pkg::bit_cnt_t              bit_cnt;
    logic [sd_pkg::FRAME_BITS-1:0] sreg;
    sd_pkg::crc7_t                 crc_next;
    logic                          load;

    assign load = (state == sd_pkg::TX_IDLE) && tx.tx_start;

    // crc runs over start, dir, index and arg only
    crc7 u_crc (
        .int_clk  (int_clk),
        .en       (en),
        .clear    (load),
        .bit_en   (sd_fall && (state == sd_pkg::TX_SHIFT)),
        .din      (sreg[sd_pkg::FRAME_BITS-1]),
        .crc      (),
        .crc_next (crc_next)
    );

    // ========================================================================
    // frame shift register
    // ========================================================================
    always_ff @(posedge int_clk) begin
        if (load) begin
            // start 0, dir 1, crc field zero until filled in
            sreg <= {2'b01, tx.tx_index, tx.tx_arg, {sd_pkg::CRC_BITS{1'b0}}, 1'b1};
        end else if (sd_fall && (state == sd_pkg::TX_SHIFT) && (bit_cnt == LAST_DATA)) begin
            // crc lands in the field that moves up next
            sreg <= {crc_next, sreg[LAST_DATA:0], 1'b0};
        end else if (sd_fall && (state != sd_pkg::TX_IDLE)) begin
            sreg <= {sreg[sd_pkg::FRAME_BITS-2:0], 1'b0};
        end
    end

    // ========================================================================
    // control fsm
    // ========================================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            state      <= sd_pkg::TX_IDLE;
            bit_cnt    <= '0;
            tx.tx_busy <= 1'b0;
            tx.tx_done <= 1'b0;
            sd_cmd_out <= 1'b1;
            sd_cmd_oe  <= 1'b0;
        end else begin
            tx.tx_done <= 1'b0;
            case (state)
                sd_pkg::TX_IDLE: begin
                    if (tx.tx_start) begin
                        state      <= sd_pkg::TX_SHIFT;
                        bit_cnt    <= '0;
                        tx.tx_busy <= 1'b1;
                    end
                end
                // bits 0..39, fed to the crc
                sd_pkg::TX_SHIFT: begin
                    if (sd_fall) begin
                        sd_cmd_out <= sreg[sd_pkg::FRAME_BITS-1];
                        sd_cmd_oe  <= 1'b1;
                        bit_cnt    <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_DATA) begin
                            state <= sd_pkg::TX_CRC;
                        end
                    end
                end
                // crc bits then the end bit
                sd_pkg::TX_CRC: begin
                    if (sd_fall) begin
                        sd_cmd_out <= sreg[sd_pkg::FRAME_BITS-1];
                        bit_cnt    <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= sd_pkg::TX_END;
                        end
                    end
                end
                // release the line, 49th fall
                sd_pkg::TX_END: begin
                    if (sd_fall) begin
                        sd_cmd_oe  <= 1'b0;
                        sd_cmd_out <= 1'b1;
                        tx.tx_busy <= 1'b0;
                        tx.tx_done <= 1'b1;
                        state      <= sd_pkg::TX_IDLE;
                    end
                end
                default: state <= sd_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

// File: cmd_path/resp_rx.sv
`timescale 1ns/10ps

module resp_rx #(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic int_clk,
    input  logic en,
    input  logic sd_rise,
    input  logic sd_cmd_in,
    sd_rx_if.receiver rx
);

    localparam int TO_W = $clog2(RESP_TIMEOUT + 1);
    localparam logic [TO_W-1:0] LAST_WAIT = TO_W'(RESP_TIMEOUT - 1);
    localparam sd_pkg::bit_cnt_t LAST_DATA =
        sd_pkg::bit_cnt_t'(sd_pkg::FRAME_BITS - sd_pkg::CRC_BITS - 2);
    localparam sd_pkg::bit_cnt_t LAST_BIT = sd_pkg::bit_cnt_t'(sd_pkg::FRAME_BITS - 1);

    sd_pkg::rx_state_e             state;
    sd_pkg::bit_cnt_t              bit_cnt;
    logic [TO_W-1:0]               tout_cnt;
    logic                          timeout_q;
    logic [sd_pkg::FRAME_BITS-1:0] sreg;
    sd_pkg::crc7_t                 crc;
    logic                          start_seen;
    logic                          take;

    // start bit while hunting
    assign start_seen = sd_rise && (state == sd_pkg::RX_HUNT) && !sd_cmd_in;
    // any sample that belongs to the frame
    assign take = start_seen || (sd_rise && (state == sd_pkg::RX_SHIFT));

    // crc over bits 47..8, start bit included
    crc7 u_crc (
        .int_clk  (int_clk),
        .en       (en),
        .clear    (rx.rx_arm),
        .bit_en   (start_seen || (take && !start_seen && (bit_cnt <= LAST_DATA))),
        .din      (sd_cmd_in),
        .crc      (crc),
        .crc_next ()
    );

    // msb of the frame arrives first
    always_ff @(posedge int_clk) begin
        if (take) begin
            sreg <= {sreg[sd_pkg::FRAME_BITS-2:0], sd_cmd_in};
        end
    end

    // ========================================================================
    // hunt, shift and timeout
    // ========================================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            state     <= sd_pkg::RX_IDLE;
            bit_cnt   <= '0;
            tout_cnt  <= '0;
            timeout_q <= 1'b0;
        end else if (rx.rx_arm) begin
            state     <= sd_pkg::RX_HUNT;
            tout_cnt  <= '0;
            timeout_q <= 1'b0;
        end else begin
            case (state)
                sd_pkg::RX_HUNT: begin
                    if (start_seen) begin
                        state   <= sd_pkg::RX_SHIFT;
                        bit_cnt <= sd_pkg::bit_cnt_t'(1);
                    end else if (sd_rise && (tout_cnt == LAST_WAIT)) begin
                        // card stayed silent
                        timeout_q <= 1'b1;
                        state     <= sd_pkg::RX_DONE;
                    end else if (sd_rise) begin
                        tout_cnt <= tout_cnt + 1'b1;
                    end
                end
                sd_pkg::RX_SHIFT: begin
                    if (sd_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= sd_pkg::RX_DONE;
                        end
                    end
                end
                // one cycle, the done pulse
                sd_pkg::RX_DONE: state <= sd_pkg::RX_IDLE;
                default:         state <= sd_pkg::RX_IDLE;
            endcase
        end
    end

    // ========================================================================
    // result fields
    // ========================================================================
    assign rx.rx_done     = (state == sd_pkg::RX_DONE);
    assign rx.rx_timeout  = timeout_q;
    assign rx.rx_index    = sreg[45:40];
    assign rx.rx_arg      = sreg[39:8];
    assign rx.rx_crc_ok   = (crc == sreg[7:1]);
    // transmission bit 0, end bit 1
    assign rx.rx_frame_ok = !sreg[46] && sreg[0];

endmodule

// File: hw/cmd_seq.sv
`timescale 1ns/10ps

module cmd_seq (
    input  logic               int_clk,
    input  logic               en,
    input  logic               start,
    input  sd_pkg::cmd_index_t cmd_index,
    input  sd_pkg::cmd_arg_t   cmd_arg,
    input  logic               expect_resp,
    output logic               busy,
    output logic               done,
    output sd_pkg::cmd_index_t resp_index,
    output sd_pkg::cmd_arg_t   resp_arg,
    output logic               crc_err,
    output logic               frame_err,
    output logic               timeout,
    sd_tx_if.sequencer         tx,
    sd_rx_if.sequencer         rx
);

    sd_pkg::seq_state_e state;
    sd_pkg::cmd_index_t idx_q;
    sd_pkg::cmd_arg_t   arg_q;
    logic               exp_q;

    assign busy     = (state != sd_pkg::SEQ_IDLE);
    assign done     = (state == sd_pkg::SEQ_DONE);
    assign tx.tx_index = idx_q;
    assign tx.tx_arg   = arg_q;
    // handoff in the very cycle the command ends
    assign rx.rx_arm   = (state == sd_pkg::SEQ_CMD) && tx.tx_done && exp_q;

    // request and response payload
    always_ff @(posedge int_clk) begin
        if ((state == sd_pkg::SEQ_IDLE) && start && !tx.tx_busy) begin
            idx_q <= cmd_index;
            arg_q <= cmd_arg;
        end
        if ((state == sd_pkg::SEQ_RESP) && rx.rx_done) begin
            resp_index <= rx.rx_index;
            resp_arg   <= rx.rx_arg;
        end
    end

    // ========================================================================
    // transaction fsm
    // ========================================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            state       <= sd_pkg::SEQ_IDLE;
            exp_q       <= 1'b0;
            tx.tx_start <= 1'b0;
            crc_err     <= 1'b0;
            frame_err   <= 1'b0;
            timeout     <= 1'b0;
        end else begin
            tx.tx_start <= 1'b0;
            case (state)
                // start while busy never reaches here
                sd_pkg::SEQ_IDLE: begin
                    // new frame only to an idle transmitter
                    if (start && !tx.tx_busy) begin
                        exp_q       <= expect_resp;
                        tx.tx_start <= 1'b1;
                        crc_err     <= 1'b0;
                        frame_err   <= 1'b0;
                        timeout     <= 1'b0;
                        state       <= sd_pkg::SEQ_CMD;
                    end
                end
                sd_pkg::SEQ_CMD: begin
                    if (tx.tx_done) begin
                        state <= exp_q ? sd_pkg::SEQ_RESP : sd_pkg::SEQ_DONE;
                    end
                end
                sd_pkg::SEQ_RESP: begin
                    if (rx.rx_done) begin
                        // crc and framing only mean something if a frame came
                        timeout   <= rx.rx_timeout;
                        crc_err   <= !rx.rx_timeout && !rx.rx_crc_ok;
                        frame_err <= !rx.rx_timeout &&
                                     (!rx.rx_frame_ok || (rx.rx_index != idx_q));
                        state     <= sd_pkg::SEQ_DONE;
                    end
                end
                sd_pkg::SEQ_DONE: state <= sd_pkg::SEQ_IDLE;
                default:          state <= sd_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

// File: hw/sd_cmd_ctrl.sv
`timescale 1ns/10ps

module sd_cmd_ctrl #(
    parameter int CLK_DIV      = 2,
    parameter int RESP_TIMEOUT = 64
) (
    input  logic               int_clk,
    input  logic               en,
    // host request
    input  logic               start,
    input  sd_pkg::cmd_index_t cmd_index,
    input  sd_pkg::cmd_arg_t   cmd_arg,
    input  logic               expect_resp,
    // status and response
    output logic               busy,
    output logic               done,
    output sd_pkg::cmd_index_t resp_index,
    output sd_pkg::cmd_arg_t   resp_arg,
    output logic               crc_err,
    output logic               frame_err,
    output logic               timeout,
    // card pins
    output logic               sd_clk,
    output logic               sd_cmd_out,
    output logic               sd_cmd_oe,
    input  logic               sd_cmd_in
);

    logic sd_rise;
    logic sd_fall;

    sd_tx_if tx_if ();
    sd_rx_if rx_if ();

    // ========================================================================
    // sd clock and the two line paths
    // ========================================================================
    sd_clk_gen #(.CLK_DIV(CLK_DIV)) u_clk_gen (
        .int_clk    (int_clk),
        .en         (en),
        .sd_clk_lvl (sd_clk),
        .sd_rise    (sd_rise),
        .sd_fall    (sd_fall)
    );

    // drives on falling edges
    cmd_tx u_cmd_tx (
        .int_clk    (int_clk),
        .en         (en),
        .sd_fall    (sd_fall),
        .tx         (tx_if.transmitter),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe)
    );

    // samples on rising edges
    resp_rx #(.RESP_TIMEOUT(RESP_TIMEOUT)) u_resp_rx (
        .int_clk   (int_clk),
        .en        (en),
        .sd_rise   (sd_rise),
        .sd_cmd_in (sd_cmd_in),
        .rx        (rx_if.receiver)
    );

    cmd_seq u_cmd_seq (
        .int_clk     (int_clk),
        .en          (en),
        .start       (start),
        .cmd_index   (cmd_index),
        .cmd_arg     (cmd_arg),
        .expect_resp (expect_resp),
        .busy        (busy),
        .done        (done),
        .resp_index  (resp_index),
        .resp_arg    (resp_arg),
        .crc_err     (crc_err),
        .frame_err   (frame_err),
        .timeout     (timeout),
        .tx          (tx_if.sequencer),
        .rx          (rx_if.sequencer)
    );

endmodule

// File: tb/sd_card_model.sv
`timescale 1ns/10ps

module sd_card_model (
    input  logic               sd_clk,
    input  logic               sd_cmd_out,
    input  logic               sd_cmd_oe,
    output logic               sd_cmd_in,
    // [0] flip a crc bit, [1] end bit 0, [2] wrong index, [3] stay silent
    input  logic [3:0]         fault,
    // last command seen on the line
    output sd_pkg::cmd_index_t dec_index,
    output sd_pkg::cmd_arg_t   dec_arg,
    output sd_pkg::crc7_t      dec_crc,
    output sd_pkg::crc7_t      calc_crc,
    output logic               dec_end,
    output int                 frame_count
);

    logic [47:0]        cmd_frame;
    logic [47:0]        resp_frame;
    logic [3:0]         fault_q;
    sd_pkg::cmd_index_t resp_index;

    // x^7 + x^3 + 1 over 40 bits, msb first
    function automatic sd_pkg::crc7_t crc7_of_bits(input logic [39:0] bits);
        sd_pkg::crc7_t c;
        logic          fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    // card drives on falling sd_clk, host samples on the rise
    task automatic send_response();
        resp_index = fault_q[2] ? (dec_index ^ 6'h01) : dec_index;
        // start 0, transmission 0, index, inverted argument
        resp_frame[47:8] = {2'b00, resp_index, ~dec_arg};
        resp_frame[7:1]  = crc7_of_bits(resp_frame[47:8]) ^ (fault_q[0] ? 7'h01 : 7'h00);
        resp_frame[0]    = !fault_q[1];
        repeat (3) @(negedge sd_clk);
        for (int i = 47; i >= 0; i--) begin
            @(negedge sd_clk);
            #1 sd_cmd_in = resp_frame[i];
        end
        // back to the pull-up level
        @(negedge sd_clk);
        #1 sd_cmd_in = 1'b1;
    endtask

    // ========================================================================
    // command hunt and answer
    // ========================================================================
    initial begin
        sd_cmd_in   = 1'b1;
        frame_count = 0;
        dec_index   = '0;
        dec_arg     = '0;
        dec_crc     = '0;
        calc_crc    = '0;
        dec_end     = 1'b0;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe && !sd_cmd_out) begin
                cmd_frame[47] = 1'b0;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk);
                    cmd_frame[i] = sd_cmd_out;
                end
                dec_index   = cmd_frame[45:40];
                dec_arg     = cmd_frame[39:8];
                dec_crc     = cmd_frame[7:1];
                dec_end     = cmd_frame[0];
                calc_crc    = crc7_of_bits(cmd_frame[47:8]);
                frame_count = frame_count + 1;
                fault_q     = fault;
                if (!fault_q[3]) begin
                    send_response();
                end
            end
        end
    end

endmodule

// File: tb/sd_cmd_chk.sv
`timescale 1ns/10ps

module sd_cmd_chk (
    input logic int_clk,
    input logic en,
    input logic start,
    input logic busy,
    input logic done,
    input logic crc_err,
    input logic frame_err,
    input logic timeout,
    input logic sd_cmd_out,
    input logic sd_cmd_oe
);

    logic done_seen;

    // done since the last accepted start
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            done_seen <= 1'b0;
        end else if (start && !busy) begin
            done_seen <= 1'b0;
        end else if (done) begin
            done_seen <= 1'b1;
        end
    end

    // released line idles high
    a_idle_high: assert property (@(posedge int_clk) disable iff (!en)
        !sd_cmd_oe |-> sd_cmd_out)
        else $error("cmd line low while output enable is off");

    a_done_pulse: assert property (@(posedge int_clk) disable iff (!en)
        done |=> !done)
        else $error("done wider than one cycle");

    a_busy_drop: assert property (@(posedge int_clk) disable iff (!en)
        done |=> !busy)
        else $error("busy still high after done");

    // flags only after the transaction finished
    a_flags_done: assert property (@(posedge int_clk) disable iff (!en)
        (crc_err || frame_err || timeout) |-> (done || done_seen))
        else $error("error flag set before done");

endmodule

bind sd_cmd_ctrl sd_cmd_chk u_chk (.*);

// File: tb/tb_sd_cmd_ctrl.sv
`timescale 1ns/10ps

module tb_sd_cmd_ctrl;

    localparam int CLK_DIV      = 2;
    localparam int RESP_TIMEOUT = 64;
    localparam int NUM_ROWS     = 10;
    localparam int DRIVE_DLY    = 1;
    // two frames, the hunt and some slack per row, in ns, doubled
    localparam int WATCHDOG_NS  =
        NUM_ROWS * (2 * 48 + RESP_TIMEOUT + 20) * 2 * CLK_DIV * 8 * 2;

    // card faults, one bit each
    localparam logic [3:0] F_NONE   = 4'b0000;
    localparam logic [3:0] F_CRC    = 4'b0001;
    localparam logic [3:0] F_END    = 4'b0010;
    localparam logic [3:0] F_INDEX  = 4'b0100;
    localparam logic [3:0] F_SILENT = 4'b1000;

    typedef struct {
        string              name;
        sd_pkg::cmd_index_t index;
        sd_pkg::cmd_arg_t   arg;
        logic               expect_resp;
        logic [3:0]         fault;
        logic               chk_resp;
        sd_pkg::cmd_index_t exp_index;
        sd_pkg::cmd_arg_t   exp_arg;
        logic               exp_crc_err;
        logic               exp_frame_err;
        logic               exp_timeout;
    } row_t;

    logic               int_clk;
    logic               en;
    logic               start;
    sd_pkg::cmd_index_t cmd_index;
    sd_pkg::cmd_arg_t   cmd_arg;
    logic               expect_resp;
    logic               busy;
    logic               done;
    sd_pkg::cmd_index_t resp_index;
    sd_pkg::cmd_arg_t   resp_arg;
    logic               crc_err;
    logic               frame_err;
    logic               timeout;
    logic               sd_clk;
    logic               sd_cmd_out;
    logic               sd_cmd_oe;
    logic               sd_cmd_in;
    logic [3:0]         fault;
    sd_pkg::cmd_index_t dec_index;
    sd_pkg::cmd_arg_t   dec_arg;
    sd_pkg::crc7_t      dec_crc;
    sd_pkg::crc7_t      calc_crc;
    logic               dec_end;
    int                 frame_count;

    row_t        rows [NUM_ROWS];
    logic [31:0] lcg_state;
    int          errors;

    sd_cmd_ctrl #(.CLK_DIV(CLK_DIV), .RESP_TIMEOUT(RESP_TIMEOUT)) DUT (.*);

    sd_card_model u_card (.*);

    initial begin
        int_clk = 1'b0;
        forever #4 int_clk = ~int_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // expected response follows from the card rules
    task automatic set_row(input int n, input string name, input sd_pkg::cmd_index_t index,
                           input sd_pkg::cmd_arg_t arg, input logic exp_resp,
                           input logic [3:0] flt, input logic e_crc, input logic e_frame,
                           input logic e_to);
        rows[n].name          = name;
        rows[n].index         = index;
        rows[n].arg           = arg;
        rows[n].expect_resp   = exp_resp;
        rows[n].fault         = flt;
        rows[n].chk_resp      = exp_resp && (flt == F_NONE);
        rows[n].exp_index     = index;
        rows[n].exp_arg       = ~arg;
        rows[n].exp_crc_err   = e_crc;
        rows[n].exp_frame_err = e_frame;
        rows[n].exp_timeout   = e_to;
    endtask

    // ========================================================================
    // stimulus table
    // ========================================================================
    task automatic build_table();
        set_row(0, "cmd0_no_resp", 6'd0, 32'h0, 1'b0, F_SILENT, 1'b0, 1'b0, 1'b0);
        set_row(1, "cmd8_good", 6'd8, 32'h0000_01aa, 1'b1, F_NONE, 1'b0, 1'b0, 1'b0);
        lcg_state = lcg_next(lcg_state);
        set_row(2, "cmd17_good", 6'd17, lcg_state, 1'b1, F_NONE, 1'b0, 1'b0, 1'b0);
        lcg_state = lcg_next(lcg_state);
        set_row(3, "cmd55_good", 6'd55, lcg_state, 1'b1, F_NONE, 1'b0, 1'b0, 1'b0);
        lcg_state = lcg_next(lcg_state);
        set_row(4, "crc_flip", 6'd13, lcg_state, 1'b1, F_CRC, 1'b1, 1'b0, 1'b0);
        lcg_state = lcg_next(lcg_state);
        set_row(5, "end_bit_low", 6'd24, lcg_state, 1'b1, F_END, 1'b0, 1'b1, 1'b0);
        lcg_state = lcg_next(lcg_state);
        set_row(6, "index_wrong", 6'd7, lcg_state, 1'b1, F_INDEX, 1'b0, 1'b1, 1'b0);
        lcg_state = lcg_next(lcg_state);
        set_row(7, "card_silent", 6'd9, lcg_state, 1'b1, F_SILENT, 1'b0, 1'b0, 1'b1);
        lcg_state = lcg_next(lcg_state);
        set_row(8, "cmd7_no_resp", 6'd7, lcg_state, 1'b0, F_SILENT, 1'b0, 1'b0, 1'b0);
        set_row(9, "cmd63_ones", 6'd63, 32'hffff_ffff, 1'b1, F_NONE, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic run_row(input row_t row);
        int frames_before;
        frames_before = frame_count;
        @(posedge int_clk);
        #DRIVE_DLY;
        cmd_index   = row.index;
        cmd_arg     = row.arg;
        expect_resp = row.expect_resp;
        fault       = row.fault;
        start       = 1'b1;
        @(posedge int_clk);
        #DRIVE_DLY start = 1'b0;
        if (!row.expect_resp) begin
            // second request while the first is on the line
            repeat (8) @(posedge int_clk);
            @(negedge int_clk);
            check({row.name, ".busy"}, 1'b1, busy);
            @(posedge int_clk);
            #DRIVE_DLY;
            cmd_index = ~row.index;
            start     = 1'b1;
            @(posedge int_clk);
            #DRIVE_DLY;
            start     = 1'b0;
            cmd_index = row.index;
        end
        // watchdog bounds this wait
        @(negedge int_clk);
        while (!done) begin
            @(negedge int_clk);
        end
        check({row.name, ".crc_err"}, row.exp_crc_err, crc_err);
        check({row.name, ".frame_err"}, row.exp_frame_err, frame_err);
        check({row.name, ".timeout"}, row.exp_timeout, timeout);
        if (row.chk_resp) begin
            check({row.name, ".resp_index"}, row.exp_index, resp_index);
            check({row.name, ".resp_arg"}, row.exp_arg, resp_arg);
        end
        // command as the card saw it
        check({row.name, ".cmd_index"}, row.index, dec_index);
        check({row.name, ".cmd_arg"}, row.arg, dec_arg);
        check({row.name, ".cmd_crc"}, calc_crc, dec_crc);
        check({row.name, ".cmd_end"}, 1'b1, dec_end);
        check({row.name, ".frames"}, frames_before + 1, frame_count);
        if (!row.expect_resp) begin
            // long enough for a stray frame to show up
            repeat (2 * sd_pkg::FRAME_BITS * 2 * CLK_DIV) @(posedge int_clk);
            @(negedge int_clk);
            check({row.name, ".frames_after"}, frames_before + 1, frame_count);
        end
        repeat (4) @(posedge int_clk);
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        errors      = 0;
        lcg_state   = 32'h7a94;
        en          = 1'b0;
        start       = 1'b0;
        cmd_index   = '0;
        cmd_arg     = '0;
        expect_resp = 1'b0;
        fault       = F_NONE;
        build_table();
        repeat (15) @(posedge int_clk);
        @(negedge int_clk);
        check("reset.sd_cmd_oe", 1'b0, sd_cmd_oe);
        check("reset.sd_cmd_out", 1'b1, sd_cmd_out);
        check("reset.sd_clk", 1'b0, sd_clk);
        check("reset.busy", 1'b0, busy);
        check("reset.done", 1'b0, done);
        check("reset.flags", 3'b000, {crc_err, frame_err, timeout});
        @(posedge int_clk);
        #DRIVE_DLY en = 1'b1;
        repeat (4) @(posedge int_clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
common/sd_pkg.sv
common/sd_cmd_ifs.sv
hw/sd_clk_gen.sv
hw/crc7.sv
cmd_path/cmd_tx.sv
cmd_path/resp_rx.sv
hw/cmd_seq.sv
hw/sd_cmd_ctrl.sv
tb/sd_card_model.sv
tb/sd_cmd_chk.sv
tb/tb_sd_cmd_ctrl.sv

// File: Makefile
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sources.f --top-module tb_sd_cmd_ctrl -Mdir obj_dir
	-./obj_dir/Vtb_sd_cmd_ctrl > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module tb_sd_cmd_ctrl

clean:
	rm -rf obj_dir $(LOG)
